//--- pe_ctrl.f
source/pe_ctrl_pkg.sv
source/tile_config.sv
source/tile_sequencer.sv
source/operand_addr_gen.sv
source/pe_ctrl.sv
test/pe_ctrl_props.sv
test/tb_pe_ctrl.sv

//--- source/operand_addr_gen.sv
`timescale 1ns/100ps
`default_nettype none

module operand_addr_gen #(
  parameter int ADDR_W = 10
) (
  input  wire                                i_clk,
  input  wire                                i_rst_n,
  input  wire pe_ctrl_pkg::seq_state_e       i_state,
  input  wire [pe_ctrl_pkg::COL_W-1:0]       i_column,
  input  wire [pe_ctrl_pkg::COL_W-1:0]       i_valid_start,
  input  wire [pe_ctrl_pkg::COL_W-1:0]       i_valid_end,
  input  wire                                i_busy_activation,
  input  wire                                i_busy_weight,
  output logic [ADDR_W-1:0]                  o_addr_a,
  output logic [ADDR_W-1:0]                  o_addr_w,
  output logic [ADDR_W-1:0]                  o_addr_p,
  output logic                               o_valid_p,
  output logic [pe_ctrl_pkg::NUM_LANES-1:0]  o_w_en
);

  import pe_ctrl_pkg::*;

  logic                 streaming;
  logic                 in_window;
  logic [NUM_LANES-1:0] w_en_nxt;

  assign streaming = (i_state == ST_GET) || (i_state == ST_EXPAND);
  assign in_window = (i_column >= i_valid_start) && (i_column <= i_valid_end);

  // column k+1 of the weight load writes lane k
  always_comb begin
    for (int k = 0; k < NUM_LANES; k++) begin
      w_en_nxt[k] = (i_state == ST_LOAD_W) && (i_column == COL_W'(k + 1));
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_w_en    <= '0;
      o_valid_p <= 1'b0;
    end else begin
      o_w_en    <= w_en_nxt;
      o_valid_p <= streaming && in_window;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_addr_a <= '0;
    end else if ((i_state == ST_NEXT_ROW) || (i_state == ST_IDLE)) begin
      o_addr_a <= '0;  // each pass restarts the activation stream
    end else if (!i_busy_activation) begin
      o_addr_a <= o_addr_a + 1'b1;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_addr_w <= '0;
    end else if (!i_busy_weight) begin
      o_addr_w <= o_addr_w + 1'b1;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_addr_p <= '0;
    end else if (o_valid_p) begin
      o_addr_p <= o_addr_p + 1'b1;  // next slot after each stored sum
    end
  end

endmodule

`default_nettype wire

//--- source/pe_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module pe_ctrl #(
  parameter int ADDR_W = 10
) (
  input  wire                                                    i_clk,
  input  wire                                                    i_rst_n,
  input  wire                                                    i_new_tile,
  input  wire pe_ctrl_pkg::ins_t                                 i_ins,
  output pe_ctrl_pkg::strategy_e                                 o_strategy,
  output logic [3:0]                                             o_a_signed,
  output logic [3:0]                                             o_w_signed,
  output logic [2:0]                                             o_a_arrange,
  output logic [1:0]                                             o_a_index,
  output logic [1:0]                                             o_w_arrange,
  output logic [1:0]                                             o_w_index,
  output logic [pe_ctrl_pkg::NUM_LANES*pe_ctrl_pkg::SHIFT_W-1:0] o_shift,
  output logic [pe_ctrl_pkg::NUM_LANES-1:0]                      o_w_en,
  output logic                                                   o_valid_p,
  output logic [ADDR_W-1:0]                                      o_addr_a,
  output logic [ADDR_W-1:0]                                      o_addr_w,
  output logic [ADDR_W-1:0]                                      o_addr_p,
  output logic                                                   o_busy_cube,
  output logic                                                   o_busy_activation,
  output logic                                                   o_busy_weight,
  output logic                                                   o_done
);

  import pe_ctrl_pkg::*;

  logic             load;
  prec_e            a_prec;
  prec_e            w_prec;
  logic [COL_W-1:0] columns;
  logic [ROW_W-1:0] rows;
  logic [COL_W-1:0] valid_start;
  logic [COL_W-1:0] valid_end;
  seq_state_e       state;
  logic [COL_W-1:0] column;

  tile_config tile_config_i (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_load        (load),
    .i_ins         (i_ins),
    .o_a_prec      (a_prec),
    .o_w_prec      (w_prec),
    .o_strategy    (o_strategy),
    .o_columns     (columns),
    .o_rows        (rows),
    .o_valid_start (valid_start),
    .o_valid_end   (valid_end),
    .o_a_signed    (o_a_signed),
    .o_w_signed    (o_w_signed),
    .o_a_arrange   (o_a_arrange),
    .o_w_arrange   (o_w_arrange),
    .o_shift       (o_shift)
  );

  tile_sequencer tile_sequencer_i (
    .i_clk             (i_clk),
    .i_rst_n           (i_rst_n),
    .i_new_tile        (i_new_tile),
    .i_a_prec          (a_prec),
    .i_w_prec          (w_prec),
    .i_columns         (columns),
    .i_rows            (rows),
    .i_valid_end       (valid_end),
    .o_load            (load),
    .o_state           (state),
    .o_column          (column),
    .o_a_index         (o_a_index),
    .o_w_index         (o_w_index),
    .o_busy_cube       (o_busy_cube),
    .o_busy_activation (o_busy_activation),
    .o_busy_weight     (o_busy_weight),
    .o_done            (o_done)
  );

  operand_addr_gen #(
    .ADDR_W (ADDR_W)
  ) operand_addr_gen_i (
    .i_clk             (i_clk),
    .i_rst_n           (i_rst_n),
    .i_state           (state),
    .i_column          (column),
    .i_valid_start     (valid_start),
    .i_valid_end       (valid_end),
    .i_busy_activation (o_busy_activation),
    .i_busy_weight     (o_busy_weight),
    .o_addr_a          (o_addr_a),
    .o_addr_w          (o_addr_w),
    .o_addr_p          (o_addr_p),
    .o_valid_p         (o_valid_p),
    .o_w_en            (o_w_en)
  );

endmodule

`default_nettype wire

//--- source/pe_ctrl_pkg.sv
`default_nettype none

package pe_ctrl_pkg;

  localparam int NUM_LANES = 16;  // PE lanes and weight rows
  localparam int SHIFT_W   = 4;
  localparam int COL_W     = 10;
  localparam int ROW_W     = 3;

  // cycles from the first activation to the first valid partial sum
  localparam int VALID_START_S1 = 6;
  localparam int VALID_START_S2 = 4;

  typedef enum logic [1:0] {
    PREC_2B = 2'd0,
    PREC_4B = 2'd1,
    PREC_8B = 2'd2  // code 3 is handled as 8 bits
  } prec_e;

  typedef enum logic {
    STRAT_1 = 1'b0,
    STRAT_2 = 1'b1
  } strategy_e;

  typedef enum logic [2:0] {
    ST_IDLE     = 3'd0,
    ST_LOAD_W   = 3'd1,
    ST_GET      = 3'd2,
    ST_EXPAND   = 3'd3,
    ST_NEXT_ROW = 3'd4,
    ST_DONE     = 3'd5
  } seq_state_e;

  typedef struct packed {
    logic [ROW_W-1:0] rows_m1;   // row passes minus one
    logic [COL_W-1:0] columns;
    strategy_e        strategy;
    logic             a_signed;
    prec_e            a_prec;
    logic             w_signed;
    prec_e            w_prec;
  } ins_t;

  // highest digit index of an operand, digit count minus one
  function automatic logic [1:0] digit_last(input prec_e prec);
    case (prec)
      PREC_2B: return 2'd0;
      PREC_4B: return 2'd1;
      default: return 2'd3;
    endcase
  endfunction

  function automatic logic [SHIFT_W-1:0] lane_shift(input logic [3:0] lane,
                                                   input prec_e     a_prec,
                                                   input prec_e     w_prec);
    logic       legal;
    logic [1:0] a_mask;
    logic [1:0] w_mask;
    logic [2:0] sum;
    legal = (a_prec <= PREC_8B) && (w_prec <= a_prec);
    a_mask = legal ? digit_last(a_prec) : 2'd3;  // anything else runs as 8x8
    w_mask = legal ? digit_last(w_prec) : 2'd3;
    // digit counts are powers of two, so the modulo is a mask
    sum = 3'(lane[1:0] & a_mask) + 3'(lane[3:2] & w_mask);
    return {sum, 1'b0};
  endfunction

endpackage

`default_nettype wire

//--- source/tile_config.sv
`timescale 1ns/100ps
`default_nettype none

module tile_config (
  input  wire                                                  i_clk,
  input  wire                                                  i_rst_n,
  input  wire                                                  i_load,
  input  wire pe_ctrl_pkg::ins_t                               i_ins,
  output pe_ctrl_pkg::prec_e                                   o_a_prec,
  output pe_ctrl_pkg::prec_e                                   o_w_prec,
  output pe_ctrl_pkg::strategy_e                               o_strategy,
  output logic [pe_ctrl_pkg::COL_W-1:0]                        o_columns,
  output logic [pe_ctrl_pkg::ROW_W-1:0]                        o_rows,
  output logic [pe_ctrl_pkg::COL_W-1:0]                        o_valid_start,
  output logic [pe_ctrl_pkg::COL_W-1:0]                        o_valid_end,
  output logic [3:0]                                           o_a_signed,
  output logic [3:0]                                           o_w_signed,
  output logic [2:0]                                           o_a_arrange,
  output logic [1:0]                                           o_w_arrange,
  output logic [pe_ctrl_pkg::NUM_LANES*pe_ctrl_pkg::SHIFT_W-1:0] o_shift
);

  import pe_ctrl_pkg::*;

  logic             a_sgn_q;
  logic             w_sgn_q;
  logic [COL_W-1:0] start_nxt;

  // both operands share the rule, the activation precision picks the case
  function automatic logic [3:0] lane_signed(input logic sgn, input prec_e a_prec);
    logic is_2b;
    logic is_8b;
    is_2b = (a_prec == PREC_2B);
    is_8b = (a_prec != PREC_2B) && (a_prec != PREC_4B);
    return {sgn, sgn & is_2b, sgn & ~is_8b, sgn & is_2b};
  endfunction

  assign start_nxt = (i_ins.strategy == STRAT_2) ? COL_W'(VALID_START_S2) :
                                                   COL_W'(VALID_START_S1);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_a_prec      <= PREC_2B;
      o_w_prec      <= PREC_2B;
      o_strategy    <= STRAT_1;
      o_columns     <= '0;
      o_rows        <= '0;
      o_valid_start <= '0;
      o_valid_end   <= '0;
      a_sgn_q       <= 1'b0;
      w_sgn_q       <= 1'b0;
    end else if (i_load) begin
      o_a_prec      <= i_ins.a_prec;
      o_w_prec      <= i_ins.w_prec;
      o_strategy    <= i_ins.strategy;
      o_columns     <= i_ins.columns;
      o_rows        <= i_ins.rows_m1;
      o_valid_start <= start_nxt;
      o_valid_end   <= start_nxt + i_ins.columns - 1'b1;  // last valid column
      a_sgn_q       <= i_ins.a_signed;
      w_sgn_q       <= i_ins.w_signed;
    end
  end

  assign o_a_signed = lane_signed(a_sgn_q, o_a_prec);
  assign o_w_signed = lane_signed(w_sgn_q, o_a_prec);

  // activation x weight
  always_comb begin
    case ({o_a_prec, o_w_prec})
      {PREC_2B, PREC_2B}: o_a_arrange = 3'd0;
      {PREC_4B, PREC_2B}: o_a_arrange = 3'd1;
      {PREC_4B, PREC_4B}: o_a_arrange = 3'd2;
      {PREC_8B, PREC_2B}: o_a_arrange = 3'd3;
      {PREC_8B, PREC_4B}: o_a_arrange = 3'd4;
      default:            o_a_arrange = 3'd5;
    endcase
  end

  always_comb begin
    case ({o_a_prec, o_w_prec})
      {PREC_2B, PREC_2B}: o_w_arrange = 2'd0;
      {PREC_4B, PREC_2B}: o_w_arrange = 2'd1;
      {PREC_4B, PREC_4B}: o_w_arrange = 2'd2;
      default:            o_w_arrange = 2'd3;
    endcase
  end

  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      o_shift[i*SHIFT_W +: SHIFT_W] = lane_shift(4'(i), o_a_prec, o_w_prec);
    end
  end

endmodule

`default_nettype wire

//--- source/tile_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module tile_sequencer (
  input  wire                            i_clk,
  input  wire                            i_rst_n,
  input  wire                            i_new_tile,
  input  wire pe_ctrl_pkg::prec_e        i_a_prec,
  input  wire pe_ctrl_pkg::prec_e        i_w_prec,
  input  wire [pe_ctrl_pkg::COL_W-1:0]   i_columns,
  input  wire [pe_ctrl_pkg::ROW_W-1:0]   i_rows,
  input  wire [pe_ctrl_pkg::COL_W-1:0]   i_valid_end,
  output logic                           o_load,
  output pe_ctrl_pkg::seq_state_e        o_state,
  output logic [pe_ctrl_pkg::COL_W-1:0]  o_column,
  output logic [1:0]                     o_a_index,
  output logic [1:0]                     o_w_index,
  output logic                           o_busy_cube,
  output logic                           o_busy_activation,
  output logic                           o_busy_weight,
  output logic                           o_done
);

  import pe_ctrl_pkg::*;

  seq_state_e       state;
  seq_state_e       state_nxt;
  logic [COL_W-1:0] col;
  logic [COL_W:0]   col_inc;
  logic [1:0]       a_cnt;
  logic [1:0]       w_cnt;
  logic [1:0]       a_last;
  logic [1:0]       w_last;
  logic [ROW_W-1:0] row_cnt;
  logic             pass_end;
  logic             col_clr;
  logic             fetch_a;
  logic             fetch_w;

  assign o_load   = i_new_tile & ~o_busy_cube;  // ignored while a tile runs
  assign o_state  = state;
  assign o_column = col;

  // activation digits step over weight digits and the other way round
  assign a_last   = digit_last(i_w_prec);
  assign w_last   = digit_last(i_a_prec);
  assign pass_end = (col == i_valid_end + 1'b1);
  assign col_inc  = {1'b0, col} + 1'b1;

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE:     if (o_load) state_nxt = ST_LOAD_W;
      ST_LOAD_W:   if (col == COL_W'(NUM_LANES)) state_nxt = ST_GET;
      ST_GET: begin
        if (pass_end) begin
          state_nxt = (row_cnt == i_rows) ? ST_DONE : ST_NEXT_ROW;
        end else if (a_last != 2'd0) begin
          state_nxt = ST_EXPAND;
        end
      end
      ST_EXPAND: begin
        if (pass_end) begin
          state_nxt = (row_cnt == i_rows) ? ST_DONE : ST_NEXT_ROW;
        end else if (a_cnt == a_last) begin
          state_nxt = ST_GET;
        end
      end
      ST_NEXT_ROW: state_nxt = ST_LOAD_W;  // reload weights for the next pass
      ST_DONE:     state_nxt = ST_IDLE;
      default:     state_nxt = ST_IDLE;
    endcase
  end

  assign col_clr = (state == ST_IDLE) || (state == ST_NEXT_ROW) ||
                   ((state == ST_LOAD_W) && (col == COL_W'(NUM_LANES)));

  assign fetch_a = (state_nxt == ST_GET) &&
                   ((state == ST_LOAD_W) || (col_inc < {1'b0, i_columns}));

  // first word on entry, then one per activation digit round
  assign fetch_w = (state_nxt == ST_LOAD_W) &&
                   ((state != ST_LOAD_W) ||
                    ((w_cnt == w_last) && (col < COL_W'(NUM_LANES - 1))));

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state <= ST_IDLE;
      col   <= '0;
      a_cnt <= 2'd0;
      w_cnt <= 2'd0;
    end else begin
      state <= state_nxt;
      col   <= col_clr ? '0 : col + 1'b1;
      a_cnt <= (state_nxt == ST_EXPAND) ? a_cnt + 2'd1 : 2'd0;
      w_cnt <= (col_clr || (w_cnt == w_last)) ? 2'd0 : w_cnt + 2'd1;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      row_cnt <= '0;
    end else if (o_load) begin
      row_cnt <= '0;
    end else if (state == ST_NEXT_ROW) begin
      row_cnt <= row_cnt + 1'b1;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_busy_cube <= 1'b0;
    end else if (o_load) begin
      o_busy_cube <= 1'b1;
    end else if (state == ST_DONE) begin
      o_busy_cube <= 1'b0;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_busy_activation <= 1'b1;  // high means no fetch
      o_busy_weight     <= 1'b1;
      o_done            <= 1'b0;
      o_a_index         <= 2'd0;
      o_w_index         <= 2'd0;
    end else begin
      o_busy_activation <= ~fetch_a;
      o_busy_weight     <= ~fetch_w;
      o_done            <= (state == ST_DONE);
      o_a_index         <= a_cnt;
      o_w_index         <= w_cnt;
    end
  end

endmodule

`default_nettype wire

//--- test/pe_ctrl_props.sv
`timescale 1ns/100ps
`default_nettype none

module pe_ctrl_props (
  input wire                          i_clk,
  input wire                          i_rst_n,
  input wire                          i_new_tile,
  input wire                          i_load,
  input wire                          i_done,
  input wire pe_ctrl_pkg::seq_state_e i_state
);

  import pe_ctrl_pkg::*;

  int fail_cnt = 0;  // failed assertions so far

  done_one_cycle: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    i_done |=> !i_done
  ) else begin
    $error("o_done stayed high for more than one cycle");
    fail_cnt++;
  end

  no_load_while_busy: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (i_new_tile && (i_state != ST_IDLE)) |-> !i_load
  ) else begin
    $error("a new tile was accepted while the sequencer was running");
    fail_cnt++;
  end

  state_legal: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    i_state inside {ST_IDLE, ST_LOAD_W, ST_GET, ST_EXPAND, ST_NEXT_ROW, ST_DONE}
  ) else begin
    $error("sequencer state outside the enum");
    fail_cnt++;
  end

endmodule

bind tile_sequencer pe_ctrl_props pe_ctrl_props_i (
  .i_clk       (i_clk),
  .i_rst_n     (i_rst_n),
  .i_new_tile  (i_new_tile),
  .i_load      (o_load),
  .i_done      (o_done),
  .i_state     (o_state)
);

`default_nettype wire

//--- test/tb_pe_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module tb_pe_ctrl;

  import pe_ctrl_pkg::*;

  localparam int ADDR_W  = 10;
  localparam int TIMEOUT = 2000;  // cycles

  logic                           i_clk;
  logic                           i_rst_n;
  logic                           i_new_tile;
  ins_t                           i_ins;
  strategy_e                      o_strategy;
  logic [3:0]                     o_a_signed;
  logic [3:0]                     o_w_signed;
  logic [2:0]                     o_a_arrange;
  logic [1:0]                     o_a_index;
  logic [1:0]                     o_w_arrange;
  logic [1:0]                     o_w_index;
  logic [NUM_LANES*SHIFT_W-1:0]   o_shift;
  logic [NUM_LANES-1:0]           o_w_en;
  logic                           o_valid_p;
  logic [ADDR_W-1:0]              o_addr_a;
  logic [ADDR_W-1:0]              o_addr_w;
  logic [ADDR_W-1:0]              o_addr_p;
  logic                           o_busy_cube;
  logic                           o_busy_activation;
  logic                           o_busy_weight;
  logic                           o_done;

  string test_name = "reset";
  int    err_cnt   = 0;
  int    test_cnt  = 0;
  int    fail_cnt  = 0;
  int    valid_cnt = 0;
  int    wen_cnt   = 0;
  int    load_cnt  = 0;
  int    done_cnt  = 0;
  int    a_idx_max = 0;
  int    w_idx_max = 0;
  int    lane_idx  = 0;  // next lane expected in a weight load
  logic  fetch_pending = 1'b0;

  pe_ctrl #(
    .ADDR_W (ADDR_W)
  ) pe_ctrl_i (
    .i_clk             (i_clk),
    .i_rst_n           (i_rst_n),
    .i_new_tile        (i_new_tile),
    .i_ins             (i_ins),
    .o_strategy        (o_strategy),
    .o_a_signed        (o_a_signed),
    .o_w_signed        (o_w_signed),
    .o_a_arrange       (o_a_arrange),
    .o_a_index         (o_a_index),
    .o_w_arrange       (o_w_arrange),
    .o_w_index         (o_w_index),
    .o_shift           (o_shift),
    .o_w_en            (o_w_en),
    .o_valid_p         (o_valid_p),
    .o_addr_a          (o_addr_a),
    .o_addr_w          (o_addr_w),
    .o_addr_p          (o_addr_p),
    .o_busy_cube       (o_busy_cube),
    .o_busy_activation (o_busy_activation),
    .o_busy_weight     (o_busy_weight),
    .o_done            (o_done)
  );

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  function automatic int prec_bits(input int code);
    if (code == 0) return 2;
    if (code == 1) return 4;
    return 8;  // code 3 as well
  endfunction

  function automatic logic [3:0] ref_signed(input logic sgn, input int a_code);
    logic [3:0] flags;
    flags    = 4'b0000;
    flags[3] = sgn;
    if (prec_bits(a_code) != 8) flags[1] = sgn;
    if (prec_bits(a_code) == 2) begin
      flags[0] = sgn;
      flags[2] = sgn;
    end
    return flags;
  endfunction

  function automatic int ref_a_arrange(input int a_code, input int w_code);
    int a;
    int w;
    a = prec_bits(a_code);
    w = prec_bits(w_code);
    if (a == 2 && w == 2) return 0;
    if (a == 4 && w == 2) return 1;
    if (a == 4 && w == 4) return 2;
    if (a == 8 && w == 2) return 3;
    if (a == 8 && w == 4) return 4;
    return 5;
  endfunction

  function automatic int ref_w_arrange(input int a_code, input int w_code);
    int a;
    int w;
    a = prec_bits(a_code);
    w = prec_bits(w_code);
    if (a == 2 && w == 2) return 0;
    if (a == 4 && w == 2) return 1;
    if (a == 4 && w == 4) return 2;
    return 3;
  endfunction

  function automatic int ref_shift(input int lane, input int a_code, input int w_code);
    int a_dig;
    int w_dig;
    a_dig = prec_bits(a_code) / 2;  // digit count of each operand
    w_dig = prec_bits(w_code) / 2;
    if (w_dig > a_dig || a_code == 3 || w_code == 3) begin
      a_dig = 4;
      w_dig = 4;
    end
    return 2 * ((lane % a_dig) + ((lane / 4) % w_dig));
  endfunction

  function automatic ins_t make_ins(input int a, input int w, input logic a_sgn,
                                    input logic w_sgn, input int strat, input int cols,
                                    input int rows_m1);
    ins_t ins;
    ins          = '0;
    ins.a_prec   = prec_e'(a);
    ins.w_prec   = prec_e'(w);
    ins.a_signed = a_sgn;
    ins.w_signed = w_sgn;
    ins.strategy = strategy_e'(strat);
    ins.columns  = COL_W'(cols);
    ins.rows_m1  = ROW_W'(rows_m1);
    return ins;
  endfunction

  task automatic check_value(input string what, input longint expected, input longint actual);
    assert (expected == actual) else begin
      $display("Error: %s %s expected %0d actual %0d", test_name, what, expected, actual);
      err_cnt++;
    end
  endtask

  task automatic report_timeout(input string why);
    $display("%s: %s", test_name, why);
    err_cnt++;
  endtask

  // strobe counting and weight-load order, sampled away from the clock edge
  always @(negedge i_clk) begin
    if (i_rst_n) begin
      if (o_valid_p) valid_cnt++;
      if (int'(o_a_index) > a_idx_max) a_idx_max = o_a_index;
      if (int'(o_w_index) > w_idx_max) w_idx_max = o_w_index;
      if (o_done) begin
        done_cnt++;
        check_value("o_busy_cube with o_done", 0, o_busy_cube);
      end
      if (o_w_en != '0) begin
        check_value("o_w_en", longint'(1) << lane_idx, o_w_en);
        wen_cnt++;
        if (o_w_en[NUM_LANES-1]) begin
          load_cnt++;
          fetch_pending = 1'b1;
        end
        lane_idx = (lane_idx + 1) % NUM_LANES;
      end else begin
        assert (lane_idx == 0) else begin
          $display("%s: weight enables stopped before lane 15", test_name);
          err_cnt++;
        end
        lane_idx = 0;
      end
      if (fetch_pending && !o_busy_activation) begin
        check_value("o_addr_a at first fetch", 0, o_addr_a);
        fetch_pending = 1'b0;
      end
    end
  end

  task automatic run_tile(input string name, input ins_t ins, input logic poke_busy);
    int                errs_before;
    int                n;
    int                passes;
    int                a_code;
    int                w_code;
    logic [ADDR_W-1:0] p_start;
    logic [ADDR_W-1:0] p_diff;
    ins_t              other;
    test_name   = name;
    errs_before = err_cnt;
    passes      = ins.rows_m1 + 1;
    a_code      = ins.a_prec;
    w_code      = ins.w_prec;
    @(posedge i_clk);
    #10;
    valid_cnt  = 0;
    wen_cnt    = 0;
    load_cnt   = 0;
    done_cnt   = 0;
    a_idx_max  = 0;
    w_idx_max  = 0;
    p_start    = o_addr_p;
    i_ins      = ins;
    i_new_tile = 1'b1;
    @(posedge i_clk);
    #10;
    i_new_tile = 1'b0;
    check_value("o_busy_cube after start", 1, o_busy_cube);
    check_value("o_strategy", ins.strategy, o_strategy);
    check_value("o_a_signed", ref_signed(ins.a_signed, a_code), o_a_signed);
    check_value("o_w_signed", ref_signed(ins.w_signed, a_code), o_w_signed);
    check_value("o_a_arrange", ref_a_arrange(a_code, w_code), o_a_arrange);
    check_value("o_w_arrange", ref_w_arrange(a_code, w_code), o_w_arrange);
    for (int lane = 0; lane < NUM_LANES; lane++) begin
      check_value($sformatf("o_shift lane %0d", lane), ref_shift(lane, a_code, w_code),
                  o_shift[lane*SHIFT_W +: SHIFT_W]);
    end
    if (poke_busy) begin
      n = 0;
      while (valid_cnt == 0 && n < TIMEOUT) begin
        @(posedge i_clk);
        n++;
      end
      if (valid_cnt == 0) begin
        report_timeout("no partial-sum valid seen in time");
      end else begin
        #10;
        other          = ins;
        other.strategy = strategy_e'(~ins.strategy);
        other.columns  = ins.columns + 3;
        i_ins          = other;  // must be ignored while busy
        i_new_tile     = 1'b1;
        @(posedge i_clk);
        #10;
        i_new_tile = 1'b0;
      end
    end
    n = 0;
    while (done_cnt == 0 && n < TIMEOUT) begin
      @(posedge i_clk);
      n++;
    end
    if (done_cnt == 0) report_timeout("o_done never pulsed");
    repeat (20) @(posedge i_clk);  // quiet window for stray strobes
    p_diff = o_addr_p - p_start;
    check_value("o_done pulses", 1, done_cnt);
    check_value("o_valid_p cycles", ins.columns * passes, valid_cnt);
    check_value("o_addr_p advance", (ins.columns * passes) % (1 << ADDR_W), p_diff);
    check_value("o_w_en pulses", NUM_LANES * passes, wen_cnt);
    check_value("weight loads", passes, load_cnt);
    // digit counters run up to the other operand's last digit
    check_value("o_a_index max", prec_bits(w_code) / 2 - 1, a_idx_max);
    check_value("o_w_index max", prec_bits(a_code) / 2 - 1, w_idx_max);
    check_value("o_busy_cube after done", 0, o_busy_cube);
    check_value("o_strategy after done", ins.strategy, o_strategy);
    test_cnt++;
    if (err_cnt == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, err_cnt - errs_before);
      fail_cnt++;
    end
  endtask

  task automatic check_reset();
    int errs_before;
    errs_before = err_cnt;
    check_value("o_busy_cube", 0, o_busy_cube);
    check_value("o_done", 0, o_done);
    check_value("o_valid_p", 0, o_valid_p);
    check_value("o_w_en", 0, o_w_en);
    check_value("o_busy_activation", 1, o_busy_activation);
    check_value("o_busy_weight", 1, o_busy_weight);
    check_value("o_addr_a", 0, o_addr_a);
    check_value("o_addr_w", 0, o_addr_w);
    check_value("o_addr_p", 0, o_addr_p);
    test_cnt++;
    if (err_cnt == errs_before) begin
      $display("test reset: ok");
    end else begin
      $display("test reset: %0d errors", err_cnt - errs_before);
      fail_cnt++;
    end
  endtask

  initial begin
    ins_t ins;
    int   prop_fails;
    void'($urandom(32'h46ae5376));
    i_rst_n    = 1'b0;
    i_new_tile = 1'b0;
    i_ins      = '0;
    repeat (4) @(posedge i_clk);
    #10;
    i_rst_n = 1'b1;
    @(posedge i_clk);
    #10;
    check_reset();
    for (int a = 0; a < 3; a++) begin
      for (int w = 0; w < 3; w++) begin
        for (int s = 0; s < 2; s++) begin
          ins = make_ins(a, w, s[0], !s[0], $urandom % 2, 1 + $urandom % 8, $urandom % 4);
          run_tile($sformatf("prec_a%0d_w%0d_s%0d", prec_bits(a), prec_bits(w), s), ins, 1'b0);
        end
      end
    end
    run_tile("strategy_1", make_ins(2, 2, 1'b1, 1'b1, 0, 5, 1), 1'b0);
    run_tile("strategy_2", make_ins(2, 1, 1'b0, 1'b1, 1, 7, 2), 1'b0);
    run_tile("busy_ignore", make_ins(1, 0, 1'b0, 1'b1, 1, 4, 2), 1'b1);
    prop_fails = pe_ctrl_i.tile_sequencer_i.pe_ctrl_props_i.fail_cnt;
    $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
             test_cnt, fail_cnt, err_cnt, prop_fails);
    if (err_cnt == 0 && prop_fails == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
